//--- hdl/sgdma_pkg.sv
`default_nettype none

package sgdma_pkg;

    ////////////////////////////////////////////////////////////
    // word and field widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH      = 32;
    localparam int ADDR_WIDTH      = 16;
    localparam int UNIT_CNT_WIDTH  = 7;
    // destination and priority bits copied from the head
    localparam int HEAD_INFO_WIDTH = 7;
    // first address, total units, head info
    localparam int DISPATCH_WIDTH  = ADDR_WIDTH + UNIT_CNT_WIDTH + HEAD_INFO_WIDTH;

    // payload byte length inside the packet head
    localparam int LEN_MSB = 17;
    localparam int LEN_LSB = 7;

    // one cell holds 16 bytes
    localparam int UNIT_BYTES_LOG2 = 4;

    ////////////////////////////////////////////////////////////
    // free list and cell address layout
    ////////////////////////////////////////////////////////////

    localparam int INIT_ADDR_COUNT  = 128;
    localparam int FP_DEPTH_LOG2    = 8;
    // port | zero pad | index
    localparam int PORT_ID_WIDTH    = 4;
    localparam int ADDR_PAD_WIDTH   = 4;
    localparam int ADDR_INDEX_WIDTH = ADDR_WIDTH - PORT_ID_WIDTH - ADDR_PAD_WIDTH;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [UNIT_CNT_WIDTH-1:0] unit_cnt_t;
    typedef logic [DISPATCH_WIDTH-1:0] dispatch_t;

    // packet writer sequence
    typedef enum logic [2:0] {IDLE, REQ, WAIT_READY, HEAD, BODY, DONE} writer_state_e;

    // free list refill request
    typedef enum logic {REFILL_IDLE, REFILL_REQ} refill_state_e;

endpackage

`default_nettype wire

//--- hdl/free_ptr_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module free_ptr_fifo
    import sgdma_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_wr_en,
    input  wire addr_t i_wr_dat,
    input  wire        i_rd_en,
    output addr_t      o_dout,
    output logic       o_full,
    output logic       o_empty
);

    localparam int DEPTH = 2 ** FP_DEPTH_LOG2;

    addr_t                    mem [DEPTH];
    logic [FP_DEPTH_LOG2-1:0] wr_ptr;
    logic [FP_DEPTH_LOG2-1:0] rd_ptr;
    // one extra bit so a full list is distinct from an empty one
    logic [FP_DEPTH_LOG2:0]   count;
    logic                     do_wr;
    logic                     do_rd;

    // push while full and pop while empty are dropped
    assign do_wr = i_wr_en && !o_full;
    assign do_rd = i_rd_en && !o_empty;

    // cell address storage
    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_dat;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the level unchanged
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fall-through read, head entry always on the output
    assign o_dout  = mem[rd_ptr];
    // msb set only at exactly DEPTH entries
    assign o_full  = count[FP_DEPTH_LOG2];
    assign o_empty = (count == '0);

endmodule

`default_nettype wire

//--- hdl/free_ptr_init.sv
`timescale 1ns/100ps
`default_nettype none

module free_ptr_init
    import sgdma_pkg::*;
#(
    parameter int unsigned PORT_ID = 0
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_fp_full,
    input  wire        i_rcy_wr_en,
    input  wire addr_t i_rcy_wr_dat,
    output logic       o_fp_wr_en,
    output addr_t      o_fp_wr_dat
);

    localparam logic [PORT_ID_WIDTH-1:0] PORT_BITS = PORT_ID_WIDTH'(PORT_ID);

    logic [ADDR_INDEX_WIDTH-1:0] fill_cnt;
    logic                        filling;
    addr_t                       init_addr;

    // fill phase lasts until INIT_ADDR_COUNT addresses are in
    assign filling   = (fill_cnt < ADDR_INDEX_WIDTH'(INIT_ADDR_COUNT));
    // port-local cell address, index taken from the counter
    assign init_addr = {PORT_BITS, {ADDR_PAD_WIDTH{1'b0}}, fill_cnt};

    // counter only moves when the write was accepted
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fill_cnt <= '0;
        end else if (filling && !i_fp_full) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // write port select
    ////////////////////////////////////////////////////////////

    // recycled writes are dropped while filling
    // after that the recycle port owns the free list
    assign o_fp_wr_en  = filling ? !i_fp_full : i_rcy_wr_en;
    assign o_fp_wr_dat = filling ? init_addr  : i_rcy_wr_dat;

endmodule

`default_nettype wire

//--- hdl/packet_writer.sv
`timescale 1ns/100ps
`default_nettype none

module packet_writer
    import sgdma_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    // input FIFO
    input  wire data_t i_dat,
    input  wire        i_empty,
    // free list, fall-through
    input  wire addr_t i_fp_dout,
    input  wire        i_fp_empty,
    input  wire        i_cb_full,
    input  wire        i_mmu_wr_ready,
    output logic       o_rd_en,
    output logic       o_fp_rd_en,
    // MMU write side
    output logic       o_mmu_wr_req,
    output logic       o_mmu_wr_en,
    output addr_t      o_mmu_wr_addr,
    output data_t      o_mmu_wr_dat,
    output logic       o_mmu_wr_done,
    // crossbar descriptor
    output dispatch_t  o_cb_din,
    output logic       o_cb_wr_en,
    // to the refill requester
    output logic       o_head_taken,
    output unit_cnt_t  o_total_units
);

    localparam int LEN_WIDTH = LEN_MSB - LEN_LSB + 1;

    writer_state_e                        state;
    unit_cnt_t                            payload_left;
    logic [LEN_WIDTH-1:0]                 head_len;
    logic [LEN_WIDTH-UNIT_BYTES_LOG2-1:0] whole_units;
    logic                                 partial_unit;
    unit_cnt_t                            payload_units;
    unit_cnt_t                            total_units;
    logic                                 both_ready;
    logic                                 pop;

    ////////////////////////////////////////////////////////////
    // head decode
    ////////////////////////////////////////////////////////////

    // only meaningful while the head word sits on i_dat
    assign head_len      = i_dat[LEN_MSB:LEN_LSB];
    assign whole_units   = head_len[LEN_WIDTH-1:UNIT_BYTES_LOG2];
    // leftover bytes need one more cell
    assign partial_unit  = |head_len[UNIT_BYTES_LOG2-1:0];
    assign payload_units = unit_cnt_t'(whole_units) + unit_cnt_t'(partial_unit);
    // plus the cell for the head itself
    assign total_units   = payload_units + unit_cnt_t'(1);

    // a unit moves only with a data word and a free cell both present
    assign both_ready = !i_empty && !i_fp_empty;
    assign pop        = both_ready && ((state == HEAD) || (state == BODY));
    assign o_rd_en    = pop;
    assign o_fp_rd_en = pop;

    ////////////////////////////////////////////////////////////
    // sequence and strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= IDLE;
            payload_left  <= '0;
            o_mmu_wr_req  <= 1'b0;
            o_mmu_wr_en   <= 1'b0;
            o_mmu_wr_done <= 1'b0;
            o_cb_wr_en    <= 1'b0;
            o_head_taken  <= 1'b0;
        end else begin
            // single-cycle pulses by default
            o_mmu_wr_req  <= 1'b0;
            o_mmu_wr_done <= 1'b0;
            o_cb_wr_en    <= 1'b0;
            o_head_taken  <= 1'b0;
            // every pop becomes one MMU write on the next edge
            o_mmu_wr_en   <= pop;
            case (state)
                IDLE: begin
                    // crossbar full only holds off a new packet
                    if (both_ready && !i_cb_full) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    o_mmu_wr_req <= 1'b1;
                    state        <= WAIT_READY;
                end
                WAIT_READY: begin
                    if (i_mmu_wr_ready) begin
                        state <= HEAD;
                    end
                end
                HEAD: begin
                    if (pop) begin
                        o_cb_wr_en   <= 1'b1;
                        o_head_taken <= 1'b1;
                        payload_left <= payload_units;
                        // zero-length payload skips the body
                        state        <= (payload_units == '0) ? DONE : BODY;
                    end
                end
                BODY: begin
                    // empty FIFO or free list just stalls here
                    if (pop) begin
                        payload_left <= payload_left - 1'b1;
                        if (payload_left == unit_cnt_t'(1)) begin
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    o_mmu_wr_done <= 1'b1;
                    state         <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // write address and data, captured with each pop
    always_ff @(posedge i_clk) begin
        if (pop) begin
            o_mmu_wr_addr <= i_fp_dout;
            o_mmu_wr_dat  <= i_dat;
        end
        // descriptor from the head cell
        if (pop && (state == HEAD)) begin
            o_cb_din      <= {i_fp_dout, total_units, i_dat[HEAD_INFO_WIDTH-1:0]};
            o_total_units <= total_units;
        end
    end

endmodule

`default_nettype wire

//--- hdl/refill_requester.sv
`timescale 1ns/100ps
`default_nettype none

module refill_requester
    import sgdma_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_head_taken,
    input  wire unit_cnt_t i_total_units,
    input  wire            i_malloc_done,
    output logic           o_aply_req,
    output unit_cnt_t      o_length
);

    refill_state_e state;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= REFILL_IDLE;
            o_length <= '0;
        end else begin
            case (state)
                REFILL_IDLE: begin
                    // latch cells used by the new packet
                    if (i_head_taken) begin
                        o_length <= i_total_units;
                        state    <= REFILL_REQ;
                    end
                end
                default: begin
                    // next head on the done cycle chains straight into a new request
                    if (i_malloc_done) begin
                        if (i_head_taken) begin
                            o_length <= i_total_units;
                        end else begin
                            state <= REFILL_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // drops in the done cycle itself
    assign o_aply_req = (state == REFILL_REQ) && !i_malloc_done;

endmodule

`default_nettype wire

//--- hdl/port_sgdma_top.sv
`timescale 1ns/100ps
`default_nettype none

module port_sgdma_top
    import sgdma_pkg::*;
#(
    parameter int unsigned PORT_ID = 0
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire data_t i_dat,
    input  wire        i_empty,
    input  wire        i_cb_full,
    input  wire        i_mmu_wr_ready,
    input  wire        i_mmu_malloc_done,
    input  wire        i_fp_wr_en,
    input  wire addr_t i_fp_wr_dat,
    output logic       o_rd_en,
    output dispatch_t  o_cb_din,
    output logic       o_cb_wr_en,
    output logic       o_mmu_wr_req,
    output logic       o_mmu_wr_en,
    output addr_t      o_mmu_wr_addr,
    output data_t      o_mmu_wr_dat,
    output logic       o_mmu_wr_done,
    output logic       o_aply_req,
    output unit_cnt_t  o_length
);

    ////////////////////////////////////////////////////////////
    // free list
    ////////////////////////////////////////////////////////////

    logic      fp_wr_en;
    addr_t     fp_wr_dat;
    logic      fp_rd_en;
    addr_t     fp_dout;
    logic      fp_full;
    logic      fp_empty;
    // writer to refill requester
    logic      head_taken;
    unit_cnt_t total_units;

    // initial fill, then recycled cells from the MMU
    free_ptr_init #(
        .PORT_ID (PORT_ID)
    ) u_free_ptr_init (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_fp_full    (fp_full),
        .i_rcy_wr_en  (i_fp_wr_en),
        .i_rcy_wr_dat (i_fp_wr_dat),
        .o_fp_wr_en   (fp_wr_en),
        .o_fp_wr_dat  (fp_wr_dat)
    );

    free_ptr_fifo u_free_ptr_fifo (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wr_en  (fp_wr_en),
        .i_wr_dat (fp_wr_dat),
        .i_rd_en  (fp_rd_en),
        .o_dout   (fp_dout),
        .o_full   (fp_full),
        .o_empty  (fp_empty)
    );

    ////////////////////////////////////////////////////////////
    // packet path
    ////////////////////////////////////////////////////////////

    packet_writer u_packet_writer (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_dat          (i_dat),
        .i_empty        (i_empty),
        .i_fp_dout      (fp_dout),
        .i_fp_empty     (fp_empty),
        .i_cb_full      (i_cb_full),
        .i_mmu_wr_ready (i_mmu_wr_ready),
        .o_rd_en        (o_rd_en),
        .o_fp_rd_en     (fp_rd_en),
        .o_mmu_wr_req   (o_mmu_wr_req),
        .o_mmu_wr_en    (o_mmu_wr_en),
        .o_mmu_wr_addr  (o_mmu_wr_addr),
        .o_mmu_wr_dat   (o_mmu_wr_dat),
        .o_mmu_wr_done  (o_mmu_wr_done),
        .o_cb_din       (o_cb_din),
        .o_cb_wr_en     (o_cb_wr_en),
        .o_head_taken   (head_taken),
        .o_total_units  (total_units)
    );

    // refill request toward the MMU allocator
    refill_requester u_refill_requester (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_head_taken  (head_taken),
        .i_total_units (total_units),
        .i_malloc_done (i_mmu_malloc_done),
        .o_aply_req    (o_aply_req),
        .o_length      (o_length)
    );

endmodule

`default_nettype wire

//--- test/tb_port_sgdma.sv
`timescale 1ns/100ps
`default_nettype none

module tb_port_sgdma
    import sgdma_pkg::*;
();

    localparam int PORT_ID      = 3;
    localparam int RESET_CYCLES = 8;
    localparam int FILL_CYCLES  = 140;
    // recycled cells go in once this many writes have drained the list
    localparam int RCY_AFTER    = 64;

    logic      i_clk;
    logic      i_rst_n;
    data_t     i_dat;
    logic      i_empty;
    logic      i_cb_full;
    logic      i_mmu_wr_ready;
    logic      i_mmu_malloc_done;
    logic      i_fp_wr_en;
    addr_t     i_fp_wr_dat;
    logic      o_rd_en;
    dispatch_t o_cb_din;
    logic      o_cb_wr_en;
    logic      o_mmu_wr_req;
    logic      o_mmu_wr_en;
    addr_t     o_mmu_wr_addr;
    data_t     o_mmu_wr_dat;
    logic      o_mmu_wr_done;
    logic      o_aply_req;
    unit_cnt_t o_length;

    // input FIFO contents in order, also the expected MMU write data
    data_t                      feed_q[$];
    unit_cnt_t                  pkt_units[$];
    logic [HEAD_INFO_WIDTH-1:0] pkt_info[$];
    int                         pkt_head_idx[$];
    addr_t                      rcy_addr[4];
    logic [31:0]                data_seed = 32'h4088;
    logic [31:0]                gap_seed  = 32'h4088;
    logic [31:0]                mmu_seed  = 32'h4088;
    logic                       feed_on;
    int feed_idx    = 0;
    int num_pkts    = 0;
    int total_units = 0;
    int cycle_limit = 0;
    int cycle_cnt   = 0;
    int checks      = 0;
    int errors      = 0;
    // scoreboard counters
    int wr_cnt      = 0;
    int pkt_wr_cnt  = 0;
    int cb_cnt      = 0;
    int done_cnt    = 0;
    int refill_cnt  = 0;
    int ready_wait  = 0;
    int malloc_wait = 0;
    logic prev_wr_en = 1'b0;
    logic prev_aply  = 1'b0;
    logic wait_ready = 1'b0;

    port_sgdma_top #(
        .PORT_ID (PORT_ID)
    ) DUT (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_dat             (i_dat),
        .i_empty           (i_empty),
        .i_cb_full         (i_cb_full),
        .i_mmu_wr_ready    (i_mmu_wr_ready),
        .i_mmu_malloc_done (i_mmu_malloc_done),
        .i_fp_wr_en        (i_fp_wr_en),
        .i_fp_wr_dat       (i_fp_wr_dat),
        .o_rd_en           (o_rd_en),
        .o_cb_din          (o_cb_din),
        .o_cb_wr_en        (o_cb_wr_en),
        .o_mmu_wr_req      (o_mmu_wr_req),
        .o_mmu_wr_en       (o_mmu_wr_en),
        .o_mmu_wr_addr     (o_mmu_wr_addr),
        .o_mmu_wr_dat      (o_mmu_wr_dat),
        .o_mmu_wr_done     (o_mmu_wr_done),
        .o_aply_req        (o_aply_req),
        .o_length          (o_length)
    );

    // 40 ns period
    always #20 i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // k-th cell popped since reset, fill order then recycled order
    function automatic addr_t expected_addr(input int k);
        addr_t a;
        a = '0;
        if (k < INIT_ADDR_COUNT) begin
            a[15:12] = PORT_ID;
            a[7:0]   = k;
        end else begin
            a = rcy_addr[k - INIT_ADDR_COUNT];
        end
        return a;
    endfunction

    task automatic flag_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_dispatch(input string name, input dispatch_t exp, input dispatch_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_units(input string name, input unit_cnt_t exp, input unit_cnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // head word from trace fields, payload words from the LCG
    task automatic add_packet(input int dest, input int prio, input int len, input int units);
        data_t head;
        int    i;
        if ((len + 15) / 16 + 1 != units) begin
            flag_failure($sformatf("trace packet %0d has a unit count that does not fit its length",
                                   num_pkts));
        end
        data_seed = lcg_next(data_seed);
        head = data_seed;
        head[LEN_MSB:LEN_LSB] = len;
        head[6:4] = prio;
        head[3:0] = dest;
        pkt_head_idx.push_back(feed_q.size());
        pkt_units.push_back(units);
        pkt_info.push_back(head[HEAD_INFO_WIDTH-1:0]);
        feed_q.push_back(head);
        for (i = 1; i < units; i++) begin
            data_seed = lcg_next(data_seed);
            feed_q.push_back(data_seed);
        end
        num_pkts++;
        total_units += units;
    endtask

    ////////////////////////////////////////////////////////////
    // input FIFO and MMU models
    ////////////////////////////////////////////////////////////

    always @(posedge i_clk) begin
        // DUT popped the word on show
        if (o_rd_en) begin
            feed_idx = feed_idx + 1;
        end
        gap_seed = lcg_next(gap_seed);
        // crossbar full now and then, only delays packet start
        i_cb_full <= (gap_seed[26:24] == 3'd0);
        // idle cycles show up as empties, mid-packet too
        if (feed_on && (feed_idx < feed_q.size()) && (gap_seed[30:28] != 3'd0)) begin
            i_empty <= 1'b0;
            i_dat   <= feed_q[feed_idx];
        end else begin
            i_empty <= 1'b1;
        end
    end

    always @(posedge i_clk) begin
        i_mmu_wr_ready    <= 1'b0;
        i_mmu_malloc_done <= 1'b0;
        // write ready after 1 to 4 cycles
        if (o_mmu_wr_req) begin
            wait_ready = 1'b1;
            mmu_seed   = lcg_next(mmu_seed);
            ready_wait = 1 + mmu_seed[29:28];
        end else if (ready_wait > 0) begin
            ready_wait--;
            if (ready_wait == 0) begin
                i_mmu_wr_ready <= 1'b1;
            end
        end
        if (wait_ready && o_mmu_wr_en) begin
            flag_failure("MMU write seen before the MMU answered the write request");
        end
        if (i_mmu_wr_ready) begin
            wait_ready = 1'b0;
        end
        // refill request, done 3 cycles after the rise
        if (o_aply_req && !prev_aply) begin
            if (refill_cnt < num_pkts) begin
                check_units($sformatf("packet %0d refill length", refill_cnt),
                            pkt_units[refill_cnt], o_length);
            end
            refill_cnt++;
            malloc_wait = 3;
        end else if (malloc_wait > 0) begin
            malloc_wait--;
            if (malloc_wait == 0) begin
                i_mmu_malloc_done <= 1'b1;
            end
        end
        if (prev_aply && !o_aply_req && !i_mmu_malloc_done) begin
            flag_failure("refill request dropped before allocation was done");
        end
        if (i_mmu_malloc_done && o_aply_req) begin
            flag_failure("refill request still high while allocation done is high");
        end
        prev_aply = o_aply_req;
    end

    ////////////////////////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////////////////////////

    always @(posedge i_clk) begin
        if (o_mmu_wr_en) begin
            if (wr_cnt < feed_q.size()) begin
                check_addr($sformatf("write %0d address", wr_cnt), expected_addr(wr_cnt),
                           o_mmu_wr_addr);
                check_data($sformatf("write %0d data", wr_cnt), feed_q[wr_cnt], o_mmu_wr_dat);
            end else begin
                flag_failure("MMU write beyond the end of the trace");
            end
            wr_cnt++;
            pkt_wr_cnt++;
        end
        // descriptor comes with the head write
        if (o_cb_wr_en) begin
            if (done_cnt < num_pkts) begin
                check_dispatch($sformatf("packet %0d descriptor", done_cnt),
                               {expected_addr(pkt_head_idx[done_cnt]), pkt_units[done_cnt],
                                pkt_info[done_cnt]}, o_cb_din);
            end
            cb_cnt++;
        end
        if (o_mmu_wr_done) begin
            if (!prev_wr_en) begin
                flag_failure("write done pulse not directly after the last write");
            end
            if (done_cnt < num_pkts) begin
                check_units($sformatf("packet %0d write count", done_cnt), pkt_units[done_cnt],
                            unit_cnt_t'(pkt_wr_cnt));
                if (cb_cnt != 1) begin
                    flag_failure($sformatf("packet %0d sent %0d crossbar descriptors, not one",
                                           done_cnt, cb_cnt));
                end
            end else begin
                flag_failure("write done pulse with no packet left in the trace");
            end
            done_cnt++;
            pkt_wr_cnt = 0;
            cb_cnt     = 0;
        end
        prev_wr_en = o_mmu_wr_en;
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        int    fd;
        int    rc;
        int    dest;
        int    prio;
        int    len;
        int    units;
        int    i;
        string line;
        i_clk             = 1'b0;
        i_rst_n           = 1'b0;
        i_dat             = '0;
        i_empty           = 1'b1;
        i_cb_full         = 1'b0;
        i_mmu_wr_ready    = 1'b0;
        i_mmu_malloc_done = 1'b0;
        i_fp_wr_en        = 1'b0;
        i_fp_wr_dat       = '0;
        feed_on           = 1'b0;
        // cells of port 3 already used by early packets
        rcy_addr[0] = 16'h3005;
        rcy_addr[1] = 16'h3021;
        rcy_addr[2] = 16'h303a;
        rcy_addr[3] = 16'h3012;
        fd = $fopen("test/port_sgdma_trace.txt", "r");
        if (fd == 0) begin
            flag_failure("cannot open test/port_sgdma_trace.txt");
        end
        // comment lines start with #
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0 && line.substr(0, 0) != "#") begin
                if ($sscanf(line, "%d %d %d %d", dest, prio, len, units) == 4) begin
                    add_packet(dest, prio, len, units);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        cycle_limit = FILL_CYCLES + 40 * total_units + 200;
        repeat (RESET_CYCLES - 1) @(posedge i_clk);
        if (o_rd_en || o_mmu_wr_req || o_mmu_wr_en || o_mmu_wr_done || o_cb_wr_en || o_aply_req) begin
            flag_failure("an output strobe is active during reset");
        end
        @(posedge i_clk);
        i_rst_n <= 1'b1;
        // free list fill
        repeat (FILL_CYCLES) @(posedge i_clk);
        feed_on <= 1'b1;
        if (num_pkts > 0) begin
            wait (wr_cnt >= RCY_AFTER);
            for (i = 0; i < 4; i++) begin
                @(posedge i_clk);
                i_fp_wr_en  <= 1'b1;
                i_fp_wr_dat <= rcy_addr[i];
            end
            @(posedge i_clk);
            i_fp_wr_en <= 1'b0;
            wait (done_cnt == num_pkts);
        end
        repeat (10) @(posedge i_clk);
        if (num_pkts == 0) begin
            flag_failure("trace holds no packets");
        end
        if (wr_cnt != total_units || refill_cnt != num_pkts || done_cnt != num_pkts) begin
            flag_failure($sformatf("%0d writes, %0d refills, %0d done pulses for %0d packets",
                                   wr_cnt, refill_cnt, done_cnt, num_pkts));
        end
        if (o_aply_req) begin
            flag_failure("refill request still pending at the end");
        end
        $display("packets %0d, writes %0d, checks %0d, errors %0d",
                 done_cnt, wr_cnt, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // limit grows with the trace length
    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress (%0d of %0d packets)",
                 cycle_cnt, done_cnt, num_pkts);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- port_sgdma.f
hdl/sgdma_pkg.sv
hdl/free_ptr_fifo.sv
hdl/free_ptr_init.sv
hdl/packet_writer.sv
hdl/refill_requester.sv
hdl/port_sgdma_top.sv
test/tb_port_sgdma.sv

//--- test/port_sgdma_trace.txt
# dest prio byte_length expected_total_units, all decimal
# total units = ceil(byte_length / 16) + 1 for the head cell
1 0 0 1
2 1 16 2
3 2 17 3
4 3 1000 64
5 4 1 2
6 5 15 2
7 6 32 3
8 7 100 8
9 0 255 17
10 1 48 4
11 2 200 14
12 3 64 5
13 4 80 6
14 5 0 1
